// File: include/periph_model.svh
// Reference model for the peripheral subsystem testbench
// Mirrors the register contents and the interrupt gateway state,
// and predicts the claim result of each target.

`ifndef PERIPH_MODEL_SVH
`define PERIPH_MODEL_SVH

localparam int ModelSrc = DefNumExtIrq + DefTimerCnt;

logic [PrioWidth-1:0] m_prio [1:ModelSrc];
logic [ModelSrc:1]    m_en [NumTargets];
logic [PrioWidth-1:0] m_thr [NumTargets];
logic [ModelSrc:1]    m_pend;
logic [ModelSrc:1]    m_busy;
logic [GpioWidth-1:0] m_led;
logic [DataWidth-1:0] m_cmp [DefTimerCnt];
logic [1:0]           m_ctrl [DefTimerCnt];

function automatic void reset_model();
    m_pend = '0;
    m_busy = '0;
    m_led  = '0;
    for (int s = 1; s <= ModelSrc; s++) begin
        m_prio[s] = '0;
    end
    for (int t = 0; t < NumTargets; t++) begin
        m_en[t]  = '0;
        m_thr[t] = '0;
    end
    for (int i = 0; i < DefTimerCnt; i++) begin
        m_cmp[i]  = '0;
        m_ctrl[i] = '0;
    end
endfunction

// An open gateway latches a high level into pending
function automatic void settle_pending(input logic [ModelSrc:1] levels);
    m_pend = m_pend | (levels & ~m_busy);
endfunction

// Highest priority above the threshold, lowest id on a tie
function automatic int best_claim_id(input int t);
    int id;
    int best;
    id   = 0;
    best = m_thr[t];
    for (int s = 1; s <= ModelSrc; s++) begin
        if (m_pend[s] && m_en[t][s] && (m_prio[s] > best)) begin
            id   = s;
            best = m_prio[s];
        end
    end
    return id;
endfunction

function automatic void take_claim(input int id);
    if (id != 0) begin
        m_pend[id] = 1'b0;
        m_busy[id] = 1'b1;
    end
endfunction

function automatic void release_gateway(input int id);
    m_busy[id] = 1'b0;
endfunction

`endif

// File: sim/tb_periph_top.sv
// Testbench for the peripheral subsystem
// Random APB traffic to the GPIO port, the timers, the interrupt
// controller and the empty slots, checked against a register model.

`timescale 1ns/1ps

module tb_periph_top;
    import periph_pkg::*;

    `include "periph_model.svh"

    localparam int Seed     = 68965;
    localparam int NumGpio  = 8;
    localparam int NumEmpty = 12;
    localparam int NumArb   = 12;

    // Each transfer costs an idle edge plus setup and access
    localparam int TotalTx   = 2 * 15 + 3 * NumGpio + NumEmpty + 10 * DefTimerCnt
                               + 14 * NumArb;
    localparam int IdleWaits = 20 + 4 * NumGpio + 20 * DefTimerCnt + 12 * NumArb;
    localparam int WatchdogCycles = (TotalTx * 3 + IdleWaits) * 2;

    logic                    clk;
    logic                    arst_n;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [AddrWidth-1:0]    paddr;
    logic [DataWidth-1:0]    pwdata;
    logic [DataWidth-1:0]    prdata;
    logic                    pready;
    logic                    pslverr;
    logic [DefNumExtIrq-1:0] ext_irq;
    logic [NumTargets-1:0]   irq;
    logic [GpioWidth-1:0]    leds;
    logic [GpioWidth-1:0]    dip;

    logic [DataWidth-1:0]    rd_data;
    logic                    rd_err;
    int                      errors;
    int                      checks;

    periph_top dut0 (
        .clk_i          ( clk     ),
        .arst_n_i       ( arst_n  ),
        .psel_i         ( psel    ),
        .penable_i      ( penable ),
        .pwrite_i       ( pwrite  ),
        .paddr_i        ( paddr   ),
        .pwdata_i       ( pwdata  ),
        .prdata_o       ( prdata  ),
        .pready_o       ( pready  ),
        .pslverr_o      ( pslverr ),
        .ext_irq_i      ( ext_irq ),
        .irq_o          ( irq     ),
        .leds_o         ( leds    ),
        .dip_switches_i ( dip     )
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (WatchdogCycles) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", WatchdogCycles);
        $display("TESTS FAILED");
        $finish;
    end

    // ------------------------------------------------------------
    // Bus helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] reg_addr(input int slot, input int offs);
        return (32'(slot) << SlotLsb) | (32'(offs) << 2);
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic transfer(input logic wr, input logic [31:0] addr,
                            input logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        check_val("pready_o", 32'(pready), 32'h1);
        rd_data = prdata;
        rd_err  = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
        transfer(1'b1, addr, data);
    endtask

    task automatic read_check(input string name, input logic [31:0] addr,
                              input logic [31:0] exp);
        transfer(1'b0, addr, 32'h0);
        check_val(name, rd_data, exp);
        check_val("pslverr_o", 32'(rd_err), 32'h0);
    endtask

    // All configuration registers against the model
    task automatic check_regs();
        for (int s = 1; s <= ModelSrc; s++) begin
            read_check("prdata_o priority", reg_addr(SlotPlic, PlicPrioBase + s),
                       32'(m_prio[s]));
        end
        for (int t = 0; t < NumTargets; t++) begin
            read_check("prdata_o enable", reg_addr(SlotPlic, PlicEnBase + t),
                       32'({m_en[t], 1'b0}));
            read_check("prdata_o threshold", reg_addr(SlotPlic, PlicThrBase + t),
                       32'(m_thr[t]));
        end
        read_check("prdata_o led", reg_addr(SlotGpio, GpioLedOffs), 32'(m_led));
        @(negedge clk);
        check_val("leds_o", 32'(leds), 32'(m_led));
        for (int i = 0; i < DefTimerCnt; i++) begin
            read_check("prdata_o count", reg_addr(SlotTimer, i * TimerStride + TmrCountOffs),
                       32'h0);
            read_check("prdata_o compare", reg_addr(SlotTimer, i * TimerStride + TmrCmpOffs),
                       m_cmp[i]);
            read_check("prdata_o control", reg_addr(SlotTimer, i * TimerStride + TmrCtrlOffs),
                       32'(m_ctrl[i]));
        end
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        logic [31:0]             data;
        logic [31:0]             cnt_a;
        logic [31:0]             cmp_a;
        logic [31:0]             ctl_a;
        logic [31:0]             pend_a;
        logic [31:0]             claim_a;
        logic [DefNumExtIrq-1:0] lvl;
        int                      slot;
        int                      offs;
        int                      cmp;
        int                      id;
        int                      t;

        void'($urandom(Seed));
        errors  = 0;
        checks  = 0;
        arst_n  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        ext_irq = '0;
        dip     = '0;
        lvl     = '0;
        reset_model();
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;

        @(negedge clk);
        check_val("irq_o", 32'(irq), 32'h0);
        check_regs();

        // GPIO
        for (int n = 0; n < NumGpio; n++) begin
            data  = $urandom;
            m_led = data[GpioWidth-1:0];
            write_word(reg_addr(SlotGpio, GpioLedOffs), data);
            @(negedge clk);
            check_val("leds_o", 32'(leds), 32'(m_led));
            read_check("prdata_o led", reg_addr(SlotGpio, GpioLedOffs), 32'(m_led));
            data = $urandom_range(0, 255);
            @(posedge clk);
            dip <= data[GpioWidth-1:0];
            repeat (3) @(posedge clk);
            read_check("prdata_o switches", reg_addr(SlotGpio, GpioSwOffs), data);
        end

        // Empty slots answer with an error
        for (int n = 0; n < NumEmpty; n++) begin
            slot = $urandom_range(3, 15);
            // Offsets that alias populated registers
            offs = $urandom_range(0, 7);
            if ($urandom_range(0, 1) == 1) begin
                transfer(1'b1, reg_addr(slot, offs), $urandom);
            end else begin
                transfer(1'b0, reg_addr(slot, offs), 32'h0);
                check_val("prdata_o empty slot", rd_data, ErrWord);
            end
            check_val("pslverr_o", 32'(rd_err), 32'h1);
        end
        check_regs();

        // Timers
        pend_a = reg_addr(SlotPlic, PlicPendOffs);
        for (int i = 0; i < DefTimerCnt; i++) begin
            cnt_a = reg_addr(SlotTimer, i * TimerStride + TmrCountOffs);
            cmp_a = reg_addr(SlotTimer, i * TimerStride + TmrCmpOffs);
            ctl_a = reg_addr(SlotTimer, i * TimerStride + TmrCtrlOffs);
            data  = $urandom;
            write_word(cnt_a, data);
            read_check("prdata_o count", cnt_a, data);
            cmp      = $urandom_range(2, 12);
            m_cmp[i] = cmp;
            write_word(cmp_a, m_cmp[i]);
            write_word(cnt_a, 32'h0);
            write_word(ctl_a, 32'h1);
            m_ctrl[i] = 2'b01;
            repeat (cmp + 4) @(posedge clk);
            // Compare hit raises the level in control bit 1
            m_ctrl[i][1] = 1'b1;
            read_check("prdata_o control", ctl_a, 32'(m_ctrl[i]));
            m_pend[DefNumExtIrq + i + 1] = 1'b1;
            read_check("prdata_o pending", pend_a, 32'({m_pend, 1'b0}));
            write_word(ctl_a, 32'h0);
            m_ctrl[i] = 2'b00;
            read_check("prdata_o control", ctl_a, 32'(m_ctrl[i]));
        end

        // Arbitration, then claim and complete
        for (int n = 0; n < NumArb; n++) begin
            lvl = $urandom_range(0, (1 << DefNumExtIrq) - 1);
            @(posedge clk);
            ext_irq <= lvl;
            for (int s = 1; s <= ModelSrc; s++) begin
                m_prio[s] = $urandom_range(0, 7);
                write_word(reg_addr(SlotPlic, PlicPrioBase + s), 32'(m_prio[s]));
            end
            for (t = 0; t < NumTargets; t++) begin
                m_en[t]  = $urandom_range(0, (1 << ModelSrc) - 1);
                m_thr[t] = $urandom_range(0, 3);
                write_word(reg_addr(SlotPlic, PlicEnBase + t), 32'({m_en[t], 1'b0}));
                write_word(reg_addr(SlotPlic, PlicThrBase + t), 32'(m_thr[t]));
            end
            repeat (3) @(posedge clk);
            settle_pending(ModelSrc'(lvl));
            @(negedge clk);
            for (t = 0; t < NumTargets; t++) begin
                check_val("irq_o", 32'(irq[t]), 32'(best_claim_id(t) != 0));
            end

            t       = $urandom_range(0, NumTargets - 1);
            claim_a = reg_addr(SlotPlic, PlicClaimBase + t);
            id      = best_claim_id(t);
            read_check("prdata_o claim", claim_a, 32'(id));
            take_claim(id);
            if (id != 0) begin
                // Gateway stays closed while the level is held
                repeat (3) @(posedge clk);
                settle_pending(ModelSrc'(lvl));
                read_check("prdata_o pending", pend_a, 32'({m_pend, 1'b0}));
                if ((id <= DefNumExtIrq) && ($urandom_range(0, 1) == 1)) begin
                    lvl[id - 1] = 1'b0;
                    @(posedge clk);
                    ext_irq <= lvl;
                end
                write_word(claim_a, 32'(id));
                release_gateway(id);
                repeat (3) @(posedge clk);
                settle_pending(ModelSrc'(lvl));
                read_check("prdata_o pending", pend_a, 32'({m_pend, 1'b0}));
            end
        end

        $display("Run finished: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: source/apb_slot_decoder.sv
// APB slot decoder
// Picks a peripheral from the slot field of the address, hands the
// word offset to all of them and muxes back the read data. Empty
// slots answer with an error and a filler word.

`timescale 1ns/1ps

module apb_slot_decoder (
    input  logic                              psel_i,
    input  logic                              penable_i,
    input  logic [periph_pkg::AddrWidth-1:0]  paddr_i,
    input  logic [periph_pkg::DataWidth-1:0]  plic_rdata_i,
    input  logic [periph_pkg::DataWidth-1:0]  timer_rdata_i,
    input  logic [periph_pkg::DataWidth-1:0]  gpio_rdata_i,
    output logic                              plic_sel_o,
    output logic                              timer_sel_o,
    output logic                              gpio_sel_o,
    output logic [periph_pkg::OffsWidth-1:0]  offs_o,
    output logic [periph_pkg::DataWidth-1:0]  prdata_o,
    output logic                              pready_o,
    output logic                              pslverr_o
);
    import periph_pkg::*;

    logic [SlotMsb-SlotLsb:0] slot;
    logic                     slot_hit;

    assign slot   = paddr_i[SlotMsb:SlotLsb];
    assign offs_o = paddr_i[OffsMsb:OffsMsb-OffsWidth+1];

    // One select per populated slot
    assign plic_sel_o  = psel_i && (slot == SlotPlic);
    assign timer_sel_o = psel_i && (slot == SlotTimer);
    assign gpio_sel_o  = psel_i && (slot == SlotGpio);

    assign slot_hit = (slot == SlotPlic) || (slot == SlotTimer) || (slot == SlotGpio);

    // No wait states
    assign pready_o  = psel_i && penable_i;
    assign pslverr_o = pready_o && !slot_hit;

    always_comb begin
        if (slot == SlotPlic) begin
            prdata_o = plic_rdata_i;
        end else if (slot == SlotTimer) begin
            prdata_o = timer_rdata_i;
        end else if (slot == SlotGpio) begin
            prdata_o = gpio_rdata_i;
        end else begin
            prdata_o = ErrWord;
        end
    end

endmodule

// File: source/gpio_port.sv
// GPIO port
// Writable LED register and a two-stage synchronizer for the
// DIP switch inputs.

`timescale 1ns/1ps

module gpio_port (
    input  logic                              clk_i,
    input  logic                              arst_n_i,
    input  logic                              sel_i,
    input  logic                              penable_i,
    input  logic                              pwrite_i,
    input  logic [periph_pkg::OffsWidth-1:0]  offs_i,
    input  logic [periph_pkg::DataWidth-1:0]  wdata_i,
    output logic [periph_pkg::DataWidth-1:0]  rdata_o,
    output logic [periph_pkg::GpioWidth-1:0]  leds_o,
    input  logic [periph_pkg::GpioWidth-1:0]  dip_switches_i
);
    import periph_pkg::*;

    logic [GpioWidth-1:0] led_q;
    logic [GpioWidth-1:0] sw_meta_q;
    logic [GpioWidth-1:0] sw_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            led_q     <= '0;
            sw_meta_q <= '0;
            sw_q      <= '0;
        end else begin
            sw_meta_q <= dip_switches_i;
            sw_q      <= sw_meta_q;
            if (sel_i && penable_i && pwrite_i && (offs_i == GpioLedOffs)) begin
                led_q <= wdata_i[GpioWidth-1:0];
            end
        end
    end

    assign leds_o = led_q;

    // Switch word is read-only
    always_comb begin
        rdata_o = '0;
        if (offs_i == GpioLedOffs) begin
            rdata_o = DataWidth'(led_q);
        end else if (offs_i == GpioSwOffs) begin
            rdata_o = DataWidth'(sw_q);
        end
    end

endmodule

// File: source/periph_pkg.sv
// Peripheral subsystem package
// Address map, bus widths and register offsets shared by the
// decoder, interrupt controller, timers and GPIO port.

package periph_pkg;

    // Bus widths
    localparam int AddrWidth = 32;
    localparam int DataWidth = 32;

    // ------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------
    localparam int SlotMsb   = 15;
    localparam int SlotLsb   = 12;
    localparam int OffsMsb   = 11;
    localparam int OffsWidth = 10;

    localparam int SlotPlic  = 0;
    localparam int SlotTimer = 1;
    localparam int SlotGpio  = 2;

    localparam logic [DataWidth-1:0] ErrWord = 32'hDEADBEEF;

    // ------------------------------------------------------------
    // Interrupt controller
    // ------------------------------------------------------------
    localparam int PrioWidth  = 3;
    localparam int NumTargets = 2;

    localparam logic [OffsWidth-1:0] PlicPrioBase  = 10'h000;
    localparam logic [OffsWidth-1:0] PlicPendOffs  = 10'h040;
    localparam logic [OffsWidth-1:0] PlicEnBase    = 10'h080;
    localparam logic [OffsWidth-1:0] PlicThrBase   = 10'h100;
    localparam logic [OffsWidth-1:0] PlicClaimBase = 10'h140;

    // Timers, one window of TimerStride words each
    localparam int TimerStride  = 4;
    localparam int TmrCountOffs = 0;
    localparam int TmrCmpOffs   = 1;
    localparam int TmrCtrlOffs  = 2;

    // GPIO
    localparam int GpioLedOffs = 0;
    localparam int GpioSwOffs  = 1;
    localparam int GpioWidth   = 8;

    // Top level defaults
    localparam int DefTimerCnt  = 2;
    localparam int DefNumExtIrq = 2;

endpackage

// File: source/periph_top.sv
// Peripheral subsystem top
// One APB slave port split into address slots for the interrupt
// controller, the compare timers and the LED/switch GPIO port.

`timescale 1ns/1ps

module periph_top #(
    parameter int TimerCnt  = periph_pkg::DefTimerCnt,
    parameter int NumExtIrq = periph_pkg::DefNumExtIrq
) (
    input  logic                               clk_i,
    input  logic                               arst_n_i,
    input  logic                               psel_i,
    input  logic                               penable_i,
    input  logic                               pwrite_i,
    input  logic [periph_pkg::AddrWidth-1:0]   paddr_i,
    input  logic [periph_pkg::DataWidth-1:0]   pwdata_i,
    output logic [periph_pkg::DataWidth-1:0]   prdata_o,
    output logic                               pready_o,
    output logic                               pslverr_o,
    input  logic [NumExtIrq-1:0]               ext_irq_i,
    output logic [periph_pkg::NumTargets-1:0]  irq_o,
    output logic [periph_pkg::GpioWidth-1:0]   leds_o,
    input  logic [periph_pkg::GpioWidth-1:0]   dip_switches_i
);
    import periph_pkg::*;

    logic                 plic_sel;
    logic                 timer_sel;
    logic                 gpio_sel;
    logic [OffsWidth-1:0] offs;
    logic [DataWidth-1:0] plic_rdata;
    logic [DataWidth-1:0] timer_rdata;
    logic [DataWidth-1:0] gpio_rdata;
    logic [TimerCnt-1:0]  timer_irq;

    apb_slot_decoder i_decoder (
        .psel_i        ( psel_i      ),
        .penable_i     ( penable_i   ),
        .paddr_i       ( paddr_i     ),
        .plic_rdata_i  ( plic_rdata  ),
        .timer_rdata_i ( timer_rdata ),
        .gpio_rdata_i  ( gpio_rdata  ),
        .plic_sel_o    ( plic_sel    ),
        .timer_sel_o   ( timer_sel   ),
        .gpio_sel_o    ( gpio_sel    ),
        .offs_o        ( offs        ),
        .prdata_o      ( prdata_o    ),
        .pready_o      ( pready_o    ),
        .pslverr_o     ( pslverr_o   )
    );

    plic_core #(
        .TimerCnt  ( TimerCnt  ),
        .NumExtIrq ( NumExtIrq )
    ) i_plic (
        .clk_i       ( clk_i      ),
        .arst_n_i    ( arst_n_i   ),
        .sel_i       ( plic_sel   ),
        .penable_i   ( penable_i  ),
        .pwrite_i    ( pwrite_i   ),
        .offs_i      ( offs       ),
        .wdata_i     ( pwdata_i   ),
        .rdata_o     ( plic_rdata ),
        .ext_irq_i   ( ext_irq_i  ),
        .timer_irq_i ( timer_irq  ),
        .irq_o       ( irq_o      )
    );

    timer_bank #(
        .TimerCnt ( TimerCnt )
    ) i_timers (
        .clk_i     ( clk_i       ),
        .arst_n_i  ( arst_n_i    ),
        .sel_i     ( timer_sel   ),
        .penable_i ( penable_i   ),
        .pwrite_i  ( pwrite_i    ),
        .offs_i    ( offs        ),
        .wdata_i   ( pwdata_i    ),
        .rdata_o   ( timer_rdata ),
        .irq_o     ( timer_irq   )
    );

    gpio_port i_gpio (
        .clk_i          ( clk_i          ),
        .arst_n_i       ( arst_n_i       ),
        .sel_i          ( gpio_sel       ),
        .penable_i      ( penable_i      ),
        .pwrite_i       ( pwrite_i       ),
        .offs_i         ( offs           ),
        .wdata_i        ( pwdata_i       ),
        .rdata_o        ( gpio_rdata     ),
        .leds_o         ( leds_o         ),
        .dip_switches_i ( dip_switches_i )
    );

endmodule

// File: source/plic_core.sv
// Platform-level interrupt controller
// Level sources with a gateway, pending bit and priority each.
// Every target has its own enables and threshold and a claim/complete
// word; its irq line is registered.

`timescale 1ns/1ps

module plic_core #(
    parameter int TimerCnt  = periph_pkg::DefTimerCnt,
    parameter int NumExtIrq = periph_pkg::DefNumExtIrq
) (
    input  logic                               clk_i,
    input  logic                               arst_n_i,
    input  logic                               sel_i,
    input  logic                               penable_i,
    input  logic                               pwrite_i,
    input  logic [periph_pkg::OffsWidth-1:0]   offs_i,
    input  logic [periph_pkg::DataWidth-1:0]   wdata_i,
    output logic [periph_pkg::DataWidth-1:0]   rdata_o,
    input  logic [NumExtIrq-1:0]               ext_irq_i,
    input  logic [TimerCnt-1:0]                timer_irq_i,
    output logic [periph_pkg::NumTargets-1:0]  irq_o
);
    import periph_pkg::*;

    localparam int NumSources = NumExtIrq + TimerCnt;
    localparam int IdWidth    = $clog2(NumSources + 1);

    logic [NumSources:1]  src;
    logic [NumSources:1]  pend_q;
    logic [NumSources:1]  busy_q;
    logic [PrioWidth-1:0] prio_q [NumSources:1];
    logic [NumSources:1]  en_q [NumTargets];
    logic [PrioWidth-1:0] thr_q [NumTargets];
    logic [IdWidth-1:0]   claim_id [NumTargets];
    logic [NumSources:1]  claim_mask;
    logic [NumSources:1]  done_mask;
    logic                 wr_en;
    logic                 rd_en;

    // External lines take the low ids, timers follow
    assign src   = {timer_irq_i, ext_irq_i};
    assign wr_en = sel_i && penable_i && pwrite_i;
    assign rd_en = sel_i && penable_i && !pwrite_i;

    // ------------------------------------------------------------
    // Arbitration, lowest id wins a tie
    // ------------------------------------------------------------
    always_comb begin
        logic [PrioWidth-1:0] best_prio;
        for (int t = 0; t < NumTargets; t++) begin
            claim_id[t] = '0;
            best_prio   = thr_q[t];
            for (int s = 1; s <= NumSources; s++) begin
                if (pend_q[s] && en_q[t][s] && (prio_q[s] > best_prio)) begin
                    claim_id[t] = IdWidth'(s);
                    best_prio   = prio_q[s];
                end
            end
        end
    end

    // Gateway updates from claim reads and complete writes
    always_comb begin
        claim_mask = '0;
        done_mask  = '0;
        for (int t = 0; t < NumTargets; t++) begin
            for (int s = 1; s <= NumSources; s++) begin
                if (offs_i == PlicClaimBase + t) begin
                    if (rd_en && (claim_id[t] == s)) begin
                        claim_mask[s] = 1'b1;
                    end
                    if (wr_en && (wdata_i == s)) begin
                        done_mask[s] = 1'b1;
                    end
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Register read
    // ------------------------------------------------------------
    always_comb begin
        rdata_o = '0;
        for (int s = 1; s <= NumSources; s++) begin
            if (offs_i == PlicPrioBase + s) begin
                rdata_o = DataWidth'(prio_q[s]);
            end
        end
        if (offs_i == PlicPendOffs) begin
            rdata_o = DataWidth'({pend_q, 1'b0});
        end
        for (int t = 0; t < NumTargets; t++) begin
            if (offs_i == PlicEnBase + t) begin
                rdata_o = DataWidth'({en_q[t], 1'b0});
            end
            if (offs_i == PlicThrBase + t) begin
                rdata_o = DataWidth'(thr_q[t]);
            end
            if (offs_i == PlicClaimBase + t) begin
                rdata_o = DataWidth'(claim_id[t]);
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pend_q <= '0;
            busy_q <= '0;
            irq_o  <= '0;
            for (int s = 1; s <= NumSources; s++) begin
                prio_q[s] <= '0;
            end
            for (int t = 0; t < NumTargets; t++) begin
                en_q[t]  <= '0;
                thr_q[t] <= '0;
            end
        end else begin
            // A claim closes the gateway and drops the pending bit
            pend_q <= (pend_q | (src & ~busy_q)) & ~claim_mask;
            busy_q <= (busy_q | claim_mask) & ~done_mask;
            for (int t = 0; t < NumTargets; t++) begin
                irq_o[t] <= (claim_id[t] != '0);
            end
            if (wr_en) begin
                for (int s = 1; s <= NumSources; s++) begin
                    if (offs_i == PlicPrioBase + s) begin
                        prio_q[s] <= wdata_i[PrioWidth-1:0];
                    end
                end
                for (int t = 0; t < NumTargets; t++) begin
                    if (offs_i == PlicEnBase + t) begin
                        en_q[t] <= wdata_i[NumSources:1];
                    end
                    if (offs_i == PlicThrBase + t) begin
                        thr_q[t] <= wdata_i[PrioWidth-1:0];
                    end
                end
            end
        end
    end

endmodule

// File: source/timer_bank.sv
// Compare timer bank
// Each timer counts up while enabled, wraps to zero after reaching
// its compare value and raises an interrupt level that holds until
// its control word is written.

`timescale 1ns/1ps

module timer_bank #(
    parameter int TimerCnt = periph_pkg::DefTimerCnt
) (
    input  logic                              clk_i,
    input  logic                              arst_n_i,
    input  logic                              sel_i,
    input  logic                              penable_i,
    input  logic                              pwrite_i,
    input  logic [periph_pkg::OffsWidth-1:0]  offs_i,
    input  logic [periph_pkg::DataWidth-1:0]  wdata_i,
    output logic [periph_pkg::DataWidth-1:0]  rdata_o,
    output logic [TimerCnt-1:0]               irq_o
);
    import periph_pkg::*;

    localparam int RegBits = $clog2(TimerStride);

    logic [DataWidth-1:0]         count_q [TimerCnt];
    logic [DataWidth-1:0]         cmp_q [TimerCnt];
    logic [TimerCnt-1:0]          en_q;
    logic [RegBits-1:0]           reg_sel;
    logic [OffsWidth-RegBits-1:0] tmr_sel;
    logic                         wr_en;

    // Upper offset bits pick the timer, lower bits the register
    assign reg_sel = offs_i[RegBits-1:0];
    assign tmr_sel = offs_i[OffsWidth-1:RegBits];
    assign wr_en   = sel_i && penable_i && pwrite_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            en_q  <= '0;
            irq_o <= '0;
            for (int i = 0; i < TimerCnt; i++) begin
                count_q[i] <= '0;
                cmp_q[i]   <= '0;
            end
        end else begin
            for (int i = 0; i < TimerCnt; i++) begin
                if (wr_en && (tmr_sel == i) && (reg_sel == TmrCountOffs)) begin
                    count_q[i] <= wdata_i;
                end else if (en_q[i]) begin
                    if (count_q[i] == cmp_q[i]) begin
                        count_q[i] <= '0;
                        irq_o[i]   <= 1'b1;
                    end else begin
                        count_q[i] <= count_q[i] + 1'b1;
                    end
                end
                if (wr_en && (tmr_sel == i) && (reg_sel == TmrCmpOffs)) begin
                    cmp_q[i] <= wdata_i;
                end
                // Control write also acknowledges the interrupt
                if (wr_en && (tmr_sel == i) && (reg_sel == TmrCtrlOffs)) begin
                    en_q[i]  <= wdata_i[0];
                    irq_o[i] <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        rdata_o = '0;
        for (int i = 0; i < TimerCnt; i++) begin
            if (tmr_sel == i) begin
                if (reg_sel == TmrCountOffs) begin
                    rdata_o = count_q[i];
                end else if (reg_sel == TmrCmpOffs) begin
                    rdata_o = cmp_q[i];
                end else if (reg_sel == TmrCtrlOffs) begin
                    rdata_o = DataWidth'({irq_o[i], en_q[i]});
                end
            end
        end
    end

endmodule

// File: tb.f
+incdir+include
source/periph_pkg.sv
source/apb_slot_decoder.sv
source/plic_core.sv
source/timer_bank.sv
source/gpio_port.sv
source/periph_top.sv
sim/tb_periph_top.sv
